//--- src/cluster_periph_pkg.sv
////////////////////////////////////////
// Cluster peripheral shared definitions:
// metric and register encodings, event
// structs, register map, reset defaults.
////////////////////////////////////////
package cluster_periph_pkg;

  localparam int unsigned CntWidth    = 48;
  localparam int unsigned CntIdxWidth = 3;

  typedef enum logic [2:0] {
    Cycle         = 3'd0,
    RetiredInstr  = 3'd1,
    RetiredLoad   = 3'd2,
    IssueFpu      = 3'd3,
    IcacheMiss    = 3'd4,
    IcacheHit     = 3'd5,
    TcdmAccessed  = 3'd6,
    TcdmCongested = 3'd7
  } perf_metric_e;

  typedef enum logic [2:0] {
    RegCntEn,
    RegClintSet,
    RegClintClear,
    RegClintState,
    RegPrefetch,
    RegCntSel,
    RegCntLo,
    RegCntHi
  } reg_id_e;

  typedef struct packed {
    logic retired_instr;
    logic retired_load;
    logic issue_fpu;
    logic icache_miss;
    logic icache_hit;
  } core_events_t;

  typedef struct packed {
    logic accessed;
    logic congested;
  } tcdm_events_t;

  // Metrics tracked right after reset, by counter index.
  localparam int unsigned NumMetricRst = 4;
  localparam perf_metric_e MetricRst [NumMetricRst] = '{
    Cycle, RetiredInstr, TcdmAccessed, IcacheMiss
  };
  localparam logic PrefetchRst = 1'b1;

  // Register map in word addresses.
  localparam logic [5:0] PerfCntEnAddr   = 6'h00;
  localparam logic [5:0] ClintSetAddr    = 6'h01;
  localparam logic [5:0] ClintClearAddr  = 6'h02;
  localparam logic [5:0] ClintStateAddr  = 6'h03;
  localparam logic [5:0] PrefetchAddr    = 6'h04;
  localparam logic [5:0] PerfCntBaseAddr = 6'h10;
  // Word offsets inside one 4-word counter slot.
  localparam logic [1:0] PerfCntSelOffs  = 2'd0;
  localparam logic [1:0] PerfCntLoOffs   = 2'd1;
  localparam logic [1:0] PerfCntHiOffs   = 2'd2;

  function automatic perf_metric_e metric_rst(int unsigned idx);
    if (idx < NumMetricRst) begin
      return MetricRst[idx];
    end
    return Cycle;
  endfunction

endpackage

//--- src/periph_reg_if.sv
////////////////////////////////////////
// Decoded register access, from the bus
// decoder to the execute and result stage.
////////////////////////////////////////
`timescale 1ns/1ps

interface periph_reg_if;

  logic                                       access;
  logic                                       we;
  cluster_periph_pkg::reg_id_e                reg_id;
  logic [cluster_periph_pkg::CntIdxWidth-1:0] cnt_idx;
  logic [31:0]                                wdata;
  // Byte enables widened to bits.
  logic [31:0]                                wmask;

  modport master (
    output access, we, reg_id, cnt_idx, wdata, wmask
  );

  modport slave (
    input access, we, reg_id, cnt_idx, wdata, wmask
  );

endinterface

//--- src/periph_bus_decode.sv
////////////////////////////////////////
// Wishbone classic slave with address
// decode, ack and err generation.
////////////////////////////////////////
`timescale 1ns/1ps

module periph_bus_decode #(
  parameter int unsigned NumPerfCounters = 4
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              wb_cyc_i,
  input  logic              wb_stb_i,
  input  logic              wb_we_i,
  input  logic [7:0]        wb_adr_i,
  input  logic [31:0]       wb_dat_i,
  input  logic [3:0]        wb_sel_i,
  output logic              wb_ack_o,
  output logic              wb_err_o,
  periph_reg_if.master      reg_o
);

  logic [5:0] word;
  logic [5:0] cnt_word;
  logic [3:0] cnt_num;
  logic       req;
  logic       hit;
  cluster_periph_pkg::reg_id_e reg_id;

  assign word     = wb_adr_i[7:2];
  assign cnt_word = word - cluster_periph_pkg::PerfCntBaseAddr;
  assign cnt_num  = cnt_word[5:2];

  // One access per handshake; the cycle after ack or err is idle.
  assign req = wb_cyc_i & wb_stb_i & ~(wb_ack_o | wb_err_o);

  always_comb begin
    hit    = 1'b1;
    reg_id = cluster_periph_pkg::RegCntEn;
    case (word)
      cluster_periph_pkg::PerfCntEnAddr:  reg_id = cluster_periph_pkg::RegCntEn;
      cluster_periph_pkg::ClintSetAddr:   reg_id = cluster_periph_pkg::RegClintSet;
      cluster_periph_pkg::ClintClearAddr: reg_id = cluster_periph_pkg::RegClintClear;
      cluster_periph_pkg::ClintStateAddr: reg_id = cluster_periph_pkg::RegClintState;
      cluster_periph_pkg::PrefetchAddr:   reg_id = cluster_periph_pkg::RegPrefetch;
      default: begin
        hit = (word >= cluster_periph_pkg::PerfCntBaseAddr) && (cnt_num < NumPerfCounters);
        case (cnt_word[1:0])
          cluster_periph_pkg::PerfCntSelOffs: reg_id = cluster_periph_pkg::RegCntSel;
          cluster_periph_pkg::PerfCntLoOffs:  reg_id = cluster_periph_pkg::RegCntLo;
          cluster_periph_pkg::PerfCntHiOffs:  reg_id = cluster_periph_pkg::RegCntHi;
          default: hit = 1'b0;
        endcase
      end
    endcase
  end

  // An unmapped access turns into a read of a write-only register:
  // read data 0 and no state change.
  assign reg_o.access  = req;
  assign reg_o.we      = wb_we_i & hit;
  assign reg_o.reg_id  = hit ? reg_id : cluster_periph_pkg::RegClintSet;
  assign reg_o.cnt_idx = cnt_num[cluster_periph_pkg::CntIdxWidth-1:0];
  assign reg_o.wdata   = wb_dat_i;
  assign reg_o.wmask   = {{8{wb_sel_i[3]}}, {8{wb_sel_i[2]}},
                          {8{wb_sel_i[1]}}, {8{wb_sel_i[0]}}};

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wb_ack_o <= 1'b0;
      wb_err_o <= 1'b0;
    end else begin
      wb_ack_o <= req & hit;
      wb_err_o <= req & ~hit;
    end
  end

endmodule

//--- src/perf_counter_bank.sv
////////////////////////////////////////
// Performance counter bank: event input
// register, counters, metric and hart
// selects, counter enables.
////////////////////////////////////////
`timescale 1ns/1ps

module perf_counter_bank #(
  parameter int unsigned NrCores         = 4,
  parameter int unsigned NumPerfCounters = 4
) (
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,
  periph_reg_if.slave                               reg_i,
  input  cluster_periph_pkg::core_events_t [NrCores-1:0] core_events_i,
  input  cluster_periph_pkg::tcdm_events_t          tcdm_events_i,
  output logic [NumPerfCounters-1:0][cluster_periph_pkg::CntWidth-1:0] cnt_o,
  output cluster_periph_pkg::perf_metric_e [NumPerfCounters-1:0] sel_metric_o,
  output logic [NumPerfCounters-1:0][$clog2(NrCores)-1:0] sel_hart_o,
  output logic [NumPerfCounters-1:0]                cnt_en_o
);

  localparam int unsigned HartW = $clog2(NrCores);
  localparam int unsigned CntW  = cluster_periph_pkg::CntWidth;
  localparam int unsigned IdxW  = cluster_periph_pkg::CntIdxWidth;

  cluster_periph_pkg::core_events_t [NrCores-1:0]         core_events_q;
  cluster_periph_pkg::tcdm_events_t                       tcdm_events_q;
  cluster_periph_pkg::perf_metric_e [NumPerfCounters-1:0] metric_q;
  logic [NumPerfCounters-1:0][CntW-1:0]  cnt_q;
  logic [NumPerfCounters-1:0][HartW-1:0] hart_q;
  logic [NumPerfCounters-1:0]            cnt_en_q;
  logic [NumPerfCounters-1:0]            inc;
  logic [31:0]                           wbits;
  logic                                  wr_en;
  logic                                  wr_sel;
  logic                                  wr_cnt;

  assign wbits  = reg_i.wdata & reg_i.wmask;
  assign wr_en  = reg_i.access & reg_i.we & (reg_i.reg_id == cluster_periph_pkg::RegCntEn);
  assign wr_sel = reg_i.access & reg_i.we & (reg_i.reg_id == cluster_periph_pkg::RegCntSel);
  assign wr_cnt = reg_i.access & reg_i.we &
                  ((reg_i.reg_id == cluster_periph_pkg::RegCntLo) ||
                   (reg_i.reg_id == cluster_periph_pkg::RegCntHi));

  // Pipeline register on the event inputs.
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      core_events_q <= '0;
      tcdm_events_q <= '0;
    end else begin
      core_events_q <= core_events_i;
      tcdm_events_q <= tcdm_events_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_en_q <= '0;
    end else if (wr_en) begin
      cnt_en_q <= (cnt_en_q & ~reg_i.wmask[NumPerfCounters-1:0]) | wbits[NumPerfCounters-1:0];
    end
  end

  for (genvar i = 0; i < NumPerfCounters; i++) begin : gen_cnt
    localparam logic [IdxW-1:0] Idx = i;
    localparam cluster_periph_pkg::perf_metric_e MetricInit = cluster_periph_pkg::metric_rst(i);

    cluster_periph_pkg::core_events_t hart_ev;
    logic                             idx_hit;

    assign idx_hit = (reg_i.cnt_idx == Idx);
    // Hart values past the last core see no events.
    assign hart_ev = (hart_q[i] < NrCores) ? core_events_q[hart_q[i]] : '0;

    always_comb begin
      case (metric_q[i])
        cluster_periph_pkg::Cycle:         inc[i] = 1'b1;
        cluster_periph_pkg::RetiredInstr:  inc[i] = hart_ev.retired_instr;
        cluster_periph_pkg::RetiredLoad:   inc[i] = hart_ev.retired_load;
        cluster_periph_pkg::IssueFpu:      inc[i] = hart_ev.issue_fpu;
        cluster_periph_pkg::IcacheMiss:    inc[i] = hart_ev.icache_miss;
        cluster_periph_pkg::IcacheHit:     inc[i] = hart_ev.icache_hit;
        cluster_periph_pkg::TcdmAccessed:  inc[i] = tcdm_events_q.accessed;
        cluster_periph_pkg::TcdmCongested: inc[i] = tcdm_events_q.congested;
        default:                           inc[i] = 1'b0;
      endcase
    end

    // Clear on write wins over counting.
    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        cnt_q[i] <= '0;
      end else if (wr_cnt && idx_hit) begin
        cnt_q[i] <= '0;
      end else if (cnt_en_q[i]) begin
        cnt_q[i] <= cnt_q[i] + CntW'(inc[i]);
      end
    end

    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        metric_q[i] <= MetricInit;
        hart_q[i]   <= '0;
      end else if (wr_sel && idx_hit) begin
        if (reg_i.wmask[0]) begin
          metric_q[i] <= cluster_periph_pkg::perf_metric_e'(reg_i.wdata[2:0]);
        end
        if (reg_i.wmask[8]) begin
          hart_q[i] <= reg_i.wdata[8 +: HartW];
        end
      end
    end
  end

  assign cnt_o        = cnt_q;
  assign sel_metric_o = metric_q;
  assign sel_hart_o   = hart_q;
  assign cnt_en_o     = cnt_en_q;

endmodule

//--- src/cluster_ctrl_regs.sv
////////////////////////////////////////
// Wake-up vector and icache prefetch
// enable registers.
////////////////////////////////////////
`timescale 1ns/1ps

module cluster_ctrl_regs #(
  parameter int unsigned NrCores = 4
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  periph_reg_if.slave        reg_i,
  output logic [NrCores-1:0] cl_clint_o,
  output logic               icache_prefetch_enable_o
);

  logic [NrCores-1:0] clint_q;
  logic [NrCores-1:0] clint_bits;
  logic               prefetch_q;
  logic               wr;

  assign wr         = reg_i.access & reg_i.we;
  assign clint_bits = reg_i.wdata[NrCores-1:0] & reg_i.wmask[NrCores-1:0];

  // Set and clear act only on bits under the byte mask.
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      clint_q <= '0;
    end else if (wr && reg_i.reg_id == cluster_periph_pkg::RegClintSet) begin
      clint_q <= clint_q | clint_bits;
    end else if (wr && reg_i.reg_id == cluster_periph_pkg::RegClintClear) begin
      clint_q <= clint_q & ~clint_bits;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      prefetch_q <= cluster_periph_pkg::PrefetchRst;
    end else if (wr && reg_i.reg_id == cluster_periph_pkg::RegPrefetch && reg_i.wmask[0]) begin
      prefetch_q <= reg_i.wdata[0];
    end
  end

  assign cl_clint_o               = clint_q;
  assign icache_prefetch_enable_o = prefetch_q;

endmodule

//--- src/periph_read_mux.sv
////////////////////////////////////////
// Read data select and output register.
////////////////////////////////////////
`timescale 1ns/1ps

module periph_read_mux #(
  parameter int unsigned NrCores         = 4,
  parameter int unsigned NumPerfCounters = 4
) (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  periph_reg_if.slave                       reg_i,
  input  logic [NumPerfCounters-1:0][cluster_periph_pkg::CntWidth-1:0] cnt_i,
  input  cluster_periph_pkg::perf_metric_e [NumPerfCounters-1:0] sel_metric_i,
  input  logic [NumPerfCounters-1:0][$clog2(NrCores)-1:0] sel_hart_i,
  input  logic [NumPerfCounters-1:0]        cnt_en_i,
  input  logic [NrCores-1:0]                clint_i,
  input  logic                              prefetch_i,
  output logic [31:0]                       wb_dat_o
);

  localparam int unsigned HartW = $clog2(NrCores);
  localparam int unsigned CntW  = cluster_periph_pkg::CntWidth;

  logic [31:0] rdata;

  always_comb begin
    rdata = '0;
    case (reg_i.reg_id)
      cluster_periph_pkg::RegCntEn:      rdata[NumPerfCounters-1:0] = cnt_en_i;
      cluster_periph_pkg::RegClintState: rdata[NrCores-1:0] = clint_i;
      cluster_periph_pkg::RegPrefetch:   rdata[0] = prefetch_i;
      cluster_periph_pkg::RegCntSel: begin
        rdata[2:0]        = sel_metric_i[reg_i.cnt_idx];
        rdata[8 +: HartW] = sel_hart_i[reg_i.cnt_idx];
      end
      cluster_periph_pkg::RegCntLo:      rdata = cnt_i[reg_i.cnt_idx][31:0];
      cluster_periph_pkg::RegCntHi:      rdata[CntW-33:0] = cnt_i[reg_i.cnt_idx][CntW-1:32];
      // Set and clear are write-only.
      default:                           rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wb_dat_o <= '0;
    end else if (reg_i.access && !reg_i.we) begin
      wb_dat_o <= rdata;
    end
  end

endmodule

//--- src/cluster_periph_top.sv
////////////////////////////////////////
// Cluster peripheral top level: bus
// decode, counters, control, read path.
////////////////////////////////////////
`timescale 1ns/1ps

module cluster_periph_top #(
  parameter int unsigned NrCores         = 4,
  parameter int unsigned NumPerfCounters = 4
) (
  input  logic                                           clk_i,
  input  logic                                           rst_n_i,
  input  logic                                           wb_cyc_i,
  input  logic                                           wb_stb_i,
  input  logic                                           wb_we_i,
  input  logic [7:0]                                     wb_adr_i,
  input  logic [31:0]                                    wb_dat_i,
  input  logic [3:0]                                     wb_sel_i,
  output logic [31:0]                                    wb_dat_o,
  output logic                                           wb_ack_o,
  output logic                                           wb_err_o,
  input  cluster_periph_pkg::core_events_t [NrCores-1:0] core_events_i,
  input  cluster_periph_pkg::tcdm_events_t               tcdm_events_i,
  output logic [NrCores-1:0]                             cl_clint_o,
  output logic                                           icache_prefetch_enable_o
);

  logic [NumPerfCounters-1:0][cluster_periph_pkg::CntWidth-1:0] cnt;
  cluster_periph_pkg::perf_metric_e [NumPerfCounters-1:0]       sel_metric;
  logic [NumPerfCounters-1:0][$clog2(NrCores)-1:0]              sel_hart;
  logic [NumPerfCounters-1:0]                                   cnt_en;
  logic [NrCores-1:0]                                           clint;
  logic                                                         prefetch;

  periph_reg_if reg_bus ();

  periph_bus_decode #(
    .NumPerfCounters (NumPerfCounters)
  ) i_decode (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_sel_i (wb_sel_i),
    .wb_ack_o (wb_ack_o),
    .wb_err_o (wb_err_o),
    .reg_o    (reg_bus.master)
  );

  perf_counter_bank #(
    .NrCores         (NrCores),
    .NumPerfCounters (NumPerfCounters)
  ) i_counters (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .reg_i         (reg_bus.slave),
    .core_events_i (core_events_i),
    .tcdm_events_i (tcdm_events_i),
    .cnt_o         (cnt),
    .sel_metric_o  (sel_metric),
    .sel_hart_o    (sel_hart),
    .cnt_en_o      (cnt_en)
  );

  cluster_ctrl_regs #(
    .NrCores (NrCores)
  ) i_ctrl (
    .clk_i                    (clk_i),
    .rst_n_i                  (rst_n_i),
    .reg_i                    (reg_bus.slave),
    .cl_clint_o               (clint),
    .icache_prefetch_enable_o (prefetch)
  );

  periph_read_mux #(
    .NrCores         (NrCores),
    .NumPerfCounters (NumPerfCounters)
  ) i_read (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .reg_i        (reg_bus.slave),
    .cnt_i        (cnt),
    .sel_metric_i (sel_metric),
    .sel_hart_i   (sel_hart),
    .cnt_en_i     (cnt_en),
    .clint_i      (clint),
    .prefetch_i   (prefetch),
    .wb_dat_o     (wb_dat_o)
  );

  assign cl_clint_o               = clint;
  assign icache_prefetch_enable_o = prefetch;

endmodule

//--- dv/tb_cluster_periph.sv
////////////////////////////////////////
// Testbench for the cluster peripheral
// with a table-driven Wishbone sequence,
// LFSR events and a counter model.
////////////////////////////////////////
`timescale 1ns/1ps

module tb_cluster_periph;

  localparam int unsigned NrCores         = 4;
  localparam int unsigned NumPerfCounters = 4;
  localparam int unsigned HartW           = $clog2(NrCores);
  localparam int unsigned CntW            = cluster_periph_pkg::CntWidth;
  localparam int unsigned NumOps          = 49;
  localparam int unsigned AckTimeout      = 20;

  // One bus operation with its expected response.
  typedef struct packed {
    logic        we;
    logic [7:0]  adr;
    logic [31:0] wdata;
    logic [3:0]  sel;
    logic [31:0] rdata_exp;
    logic        use_model;
    logic        exp_err;
    logic [7:0]  idle;
  } bus_op_t;

  logic        clk;
  logic        rst_n;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [7:0]  wb_adr;
  logic [31:0] wb_dat;
  logic [3:0]  wb_sel;
  logic [31:0] wb_dat_o;
  logic        wb_ack_o;
  logic        wb_err_o;
  logic [NrCores-1:0] cl_clint;
  logic               prefetch_en;
  cluster_periph_pkg::core_events_t [NrCores-1:0] core_events;
  cluster_periph_pkg::tcdm_events_t               tcdm_events;

  logic [31:0] lfsr;
  bus_op_t     ops [NumOps];

  // Reference state.
  logic [CntW-1:0]            mcnt [NumPerfCounters];
  logic [2:0]                 mmetric [NumPerfCounters];
  logic [HartW-1:0]           mhart [NumPerfCounters];
  logic [NumPerfCounters-1:0] men;
  logic [NrCores-1:0]         mclint;
  logic                       mprefetch;
  logic                       mbusy;
  logic [31:0]                model_rdata;
  cluster_periph_pkg::core_events_t [NrCores-1:0] mcore_q;
  cluster_periph_pkg::tcdm_events_t               mtcdm_q;

  cluster_periph_top #(
    .NrCores         (NrCores),
    .NumPerfCounters (NumPerfCounters)
  ) uut (
    .clk_i                    (clk),
    .rst_n_i                  (rst_n),
    .wb_cyc_i                 (wb_cyc),
    .wb_stb_i                 (wb_stb),
    .wb_we_i                  (wb_we),
    .wb_adr_i                 (wb_adr),
    .wb_dat_i                 (wb_dat),
    .wb_sel_i                 (wb_sel),
    .wb_dat_o                 (wb_dat_o),
    .wb_ack_o                 (wb_ack_o),
    .wb_err_o                 (wb_err_o),
    .core_events_i            (core_events),
    .tcdm_events_i            (tcdm_events),
    .cl_clint_o               (cl_clint),
    .icache_prefetch_enable_o (prefetch_en)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Galois LFSR with taps 32, 22, 2 and 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h8020_0003;
    end
    return state >> 1;
  endfunction

  task automatic draw_bit(output logic b);
    lfsr = lfsr_next(lfsr);
    b    = lfsr[0];
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      $display("Simulation finished: FAIL");
      $fatal(1, "value check failed");
    end
  endtask

  // Whether the registered events advance a counter with this select.
  function automatic logic event_hit(input logic [2:0] metric, input logic [HartW-1:0] hart);
    case (metric)
      cluster_periph_pkg::Cycle:         return 1'b1;
      cluster_periph_pkg::RetiredInstr:  return mcore_q[hart].retired_instr;
      cluster_periph_pkg::RetiredLoad:   return mcore_q[hart].retired_load;
      cluster_periph_pkg::IssueFpu:      return mcore_q[hart].issue_fpu;
      cluster_periph_pkg::IcacheMiss:    return mcore_q[hart].icache_miss;
      cluster_periph_pkg::IcacheHit:     return mcore_q[hart].icache_hit;
      cluster_periph_pkg::TcdmAccessed:  return mtcdm_q.accessed;
      default:                           return mtcdm_q.congested;
    endcase
  endfunction

  // New random events every cycle 10 ns after the edge.
  always @(posedge clk) begin : event_drive
    logic [4:0] ev;
    logic       b;
    #10;
    for (int c = 0; c < NrCores; c++) begin
      for (int k = 0; k < 5; k++) begin
        draw_bit(b);
        ev[k] = b;
      end
      core_events[c] = ev;
    end
    draw_bit(b);
    tcdm_events.accessed = b;
    draw_bit(b);
    tcdm_events.congested = b;
  end

  // Register and counter model that updates on the same edge as the DUT.
  always @(posedge clk) begin : model
    logic [5:0]  word;
    logic [1:0]  offs;
    logic [31:0] mask;
    logic        req;
    logic        wr;
    logic        rd;
    logic        cnt_reg;
    int          idx;
    word    = wb_adr[7:2];
    offs    = word[1:0];
    mask    = {{8{wb_sel[3]}}, {8{wb_sel[2]}}, {8{wb_sel[1]}}, {8{wb_sel[0]}}};
    idx     = (word >= 6'h10) ? int'((word - 6'h10) >> 2) : 99;
    cnt_reg = (idx < NumPerfCounters) && (offs != 2'd3);
    // No request is taken in the cycle right after an answer.
    req     = wb_cyc & wb_stb & ~mbusy;
    wr      = req & wb_we;
    rd      = req & ~wb_we;
    if (!rst_n) begin
      for (int i = 0; i < NumPerfCounters; i++) begin
        mcnt[i]  = '0;
        mhart[i] = '0;
      end
      mmetric[0] = cluster_periph_pkg::Cycle;
      mmetric[1] = cluster_periph_pkg::RetiredInstr;
      mmetric[2] = cluster_periph_pkg::TcdmAccessed;
      mmetric[3] = cluster_periph_pkg::IcacheMiss;
      men        = '0;
      mclint     = '0;
      mprefetch  = 1'b1;
      mbusy      = 1'b0;
      mcore_q    = '0;
      mtcdm_q    = '0;
    end else begin
      mbusy = req;
      // Reads see the state from before the edge.
      if (rd && cnt_reg && offs == 2'd1) begin
        model_rdata = mcnt[idx][31:0];
      end
      if (rd && cnt_reg && offs == 2'd2) begin
        model_rdata = {16'h0, mcnt[idx][47:32]};
      end
      for (int i = 0; i < NumPerfCounters; i++) begin
        if (wr && cnt_reg && idx == i && offs != 2'd0) begin
          mcnt[i] = '0;
        end else if (men[i] && event_hit(mmetric[i], mhart[i])) begin
          mcnt[i] = mcnt[i] + 1;
        end
      end
      mcore_q = core_events;
      mtcdm_q = tcdm_events;
      if (wr && word == 6'h00) begin
        men = (men & ~mask[NumPerfCounters-1:0]) |
              (wb_dat[NumPerfCounters-1:0] & mask[NumPerfCounters-1:0]);
      end
      if (wr && word == 6'h01) begin
        mclint = mclint | (wb_dat[NrCores-1:0] & mask[NrCores-1:0]);
      end
      if (wr && word == 6'h02) begin
        mclint = mclint & ~(wb_dat[NrCores-1:0] & mask[NrCores-1:0]);
      end
      if (wr && word == 6'h04 && wb_sel[0]) begin
        mprefetch = wb_dat[0];
      end
      if (wr && cnt_reg && offs == 2'd0) begin
        if (wb_sel[0]) begin
          mmetric[idx] = wb_dat[2:0];
        end
        if (wb_sel[1]) begin
          mhart[idx] = wb_dat[8 +: HartW];
        end
      end
    end
  end

  // One Wishbone classic cycle with the request held one edge past the answer.
  task automatic bus_access(input bus_op_t op);
    int waited;
    waited = 0;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = op.we;
    wb_adr = op.adr;
    wb_dat = op.wdata;
    wb_sel = op.sel;
    while (!(wb_ack_o || wb_err_o) && waited < AckTimeout) begin
      @(posedge clk);
      #10;
      waited++;
    end
    if (!(wb_ack_o || wb_err_o)) begin
      $display("No ack or err within %0d cycles for address %h.", AckTimeout, op.adr);
      $display("Simulation finished: FAIL");
      $fatal(1, "bus timeout");
    end else begin
      check_value("wb_err_o", wb_err_o, op.exp_err);
      check_value("wb_ack_o", wb_ack_o, !op.exp_err);
      if (!op.we) begin
        check_value("wb_dat_o", wb_dat_o, op.use_model ? model_rdata : op.rdata_exp);
      end
      check_value("cl_clint_o", cl_clint, mclint);
      check_value("icache_prefetch_enable_o", prefetch_en, mprefetch);
      @(posedge clk);
      #10;
      // Ack and err last a single cycle even with the request still up.
      check_value("wb_ack_o", wb_ack_o, 1'b0);
      check_value("wb_err_o", wb_err_o, 1'b0);
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      repeat (op.idle) begin
        @(posedge clk);
        #10;
      end
    end
  endtask

  initial begin : stimulus
    rst_n       = 1'b0;
    wb_cyc      = 1'b0;
    wb_stb      = 1'b0;
    wb_we       = 1'b0;
    wb_adr      = '0;
    wb_dat      = '0;
    wb_sel      = '0;
    core_events = '0;
    tcdm_events = '0;
    model_rdata = '0;
    lfsr        = 32'h2405;
    // we, adr, wdata, sel, rdata_exp, use_model, exp_err, idle
    ops = '{
      '{1'b0, 8'h00, 32'h0, 4'hf, 32'h0, 1'b0, 1'b0, 8'd0},
      '{1'b0, 8'h40, 32'h0, 4'hf, 32'h0, 1'b0, 1'b0, 8'd0},
      '{1'b0, 8'h50, 32'h0, 4'hf, 32'h1, 1'b0, 1'b0, 8'd0},
      '{1'b0, 8'h60, 32'h0, 4'hf, 32'h6, 1'b0, 1'b0, 8'd0},
      '{1'b0, 8'h70, 32'h0, 4'hf, 32'h4, 1'b0, 1'b0, 8'd0},
      '{1'b0, 8'h10, 32'h0, 4'hf, 32'h1, 1'b0, 1'b0, 8'd0},
      '{1'b0, 8'h0c, 32'h0, 4'hf, 32'h0, 1'b0, 1'b0, 8'd0},
      // Wake-up set and clear under byte masks.
      '{1'b1, 8'h04, 32'hf, 4'h1, 32'h0, 1'b0, 1'b0, 8'd0},
      '{1'b0, 8'h0c, 32'h0, 4'hf, 32'hf, 1'b0, 1'b0, 8'd0},
      '{1'b1, 8'h08, 32'h5, 4'h2, 32'h0, 1'b0, 1'b0, 8'd0},
      '{1'b0, 8'h0c, 32'h0, 4'hf, 32'hf, 1'b0, 1'b0, 8'd0},
      '{1'b1, 8'h08, 32'h5, 4'h1, 32'h0, 1'b0, 1'b0, 8'd0},
      '{1'b0, 8'h0c, 32'h0, 4'hf, 32'ha, 1'b0, 1'b0, 8'd0},
      // Prefetch enable.
      '{1'b1, 8'h10, 32'h0, 4'he, 32'h0, 1'b0, 1'b0, 8'd0},
      '{1'b0, 8'h10, 32'h0, 4'hf, 32'h1, 1'b0, 1'b0, 8'd0},
      '{1'b1, 8'h10, 32'h0, 4'h1, 32'h0, 1'b0, 1'b0, 8'd0},
      '{1'b0, 8'h10, 32'h0, 4'hf, 32'h0, 1'b0, 1'b0, 8'd0},
      // Metric and hart selects with the hart truncated to two bits.
      '{1'b1, 8'h50, 32'h203, 4'h2, 32'h0, 1'b0, 1'b0, 8'd0},
      '{1'b0, 8'h50, 32'h0, 4'hf, 32'h201, 1'b0, 1'b0, 8'd0},
      '{1'b1, 8'h50, 32'h705, 4'h3, 32'h0, 1'b0, 1'b0, 8'd0},
      '{1'b0, 8'h50, 32'h0, 4'hf, 32'h305, 1'b0, 1'b0, 8'd0},
      '{1'b1, 8'h70, 32'h100, 4'h2, 32'h0, 1'b0, 1'b0, 8'd0},
      '{1'b0, 8'h70, 32'h0, 4'hf, 32'h104, 1'b0, 1'b0, 8'd0},
      // Run all counters, stop them, read both halves.
      '{1'b1, 8'h00, 32'hf, 4'h1, 32'h0, 1'b0, 1'b0, 8'd40},
      '{1'b0, 8'h00, 32'h0, 4'hf, 32'hf, 1'b0, 1'b0, 8'd0},
      '{1'b1, 8'h00, 32'h0, 4'h1, 32'h0, 1'b0, 1'b0, 8'd2},
      '{1'b0, 8'h44, 32'h0, 4'hf, 32'h0, 1'b1, 1'b0, 8'd0},
      '{1'b0, 8'h48, 32'h0, 4'hf, 32'h0, 1'b1, 1'b0, 8'd0},
      '{1'b0, 8'h54, 32'h0, 4'hf, 32'h0, 1'b1, 1'b0, 8'd0},
      '{1'b0, 8'h58, 32'h0, 4'hf, 32'h0, 1'b1, 1'b0, 8'd0},
      '{1'b0, 8'h64, 32'h0, 4'hf, 32'h0, 1'b1, 1'b0, 8'd0},
      '{1'b0, 8'h68, 32'h0, 4'hf, 32'h0, 1'b1, 1'b0, 8'd0},
      '{1'b0, 8'h74, 32'h0, 4'hf, 32'h0, 1'b1, 1'b0, 8'd0},
      '{1'b0, 8'h78, 32'h0, 4'hf, 32'h0, 1'b1, 1'b0, 8'd0},
      // Clear while counting; counter 1 stays disabled.
      '{1'b1, 8'h00, 32'h1, 4'h1, 32'h0, 1'b0, 1'b0, 8'd10},
      '{1'b1, 8'h44, 32'h0, 4'hf, 32'h0, 1'b0, 1'b0, 8'd5},
      '{1'b0, 8'h44, 32'h0, 4'hf, 32'h0, 1'b1, 1'b0, 8'd0},
      '{1'b0, 8'h54, 32'h0, 4'hf, 32'h0, 1'b1, 1'b0, 8'd0},
      '{1'b1, 8'h58, 32'h0, 4'hf, 32'h0, 1'b0, 1'b0, 8'd0},
      '{1'b0, 8'h54, 32'h0, 4'hf, 32'h0, 1'b1, 1'b0, 8'd0},
      '{1'b1, 8'h00, 32'h0, 4'h1, 32'h0, 1'b0, 1'b0, 8'd0},
      // Unmapped word, counter index 8, counter index 4, slot hole.
      '{1'b0, 8'h14, 32'h0, 4'hf, 32'h0, 1'b0, 1'b1, 8'd0},
      '{1'b1, 8'hc0, 32'hffff_ffff, 4'hf, 32'h0, 1'b0, 1'b1, 8'd0},
      '{1'b0, 8'h84, 32'h0, 4'hf, 32'h0, 1'b0, 1'b1, 8'd0},
      '{1'b0, 8'h4c, 32'h0, 4'hf, 32'h0, 1'b0, 1'b1, 8'd0},
      '{1'b0, 8'h00, 32'h0, 4'hf, 32'h0, 1'b0, 1'b0, 8'd0},
      '{1'b0, 8'h0c, 32'h0, 4'hf, 32'ha, 1'b0, 1'b0, 8'd0},
      '{1'b0, 8'h10, 32'h0, 4'hf, 32'h0, 1'b0, 1'b0, 8'd0},
      '{1'b0, 8'h40, 32'h0, 4'hf, 32'h0, 1'b0, 1'b0, 8'd0}
    };
    repeat (10) @(posedge clk);
    #10;
    rst_n = 1'b1;
    for (int n = 0; n < NumOps; n++) begin
      bus_access(ops[n]);
    end
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

//--- vlog.f
src/cluster_periph_pkg.sv
src/periph_reg_if.sv
src/periph_bus_decode.sv
src/perf_counter_bank.sv
src/cluster_ctrl_regs.sv
src/periph_read_mux.sv
src/cluster_periph_top.sv
dv/tb_cluster_periph.sv

//--- Bender.yml
package:
  name: cluster_periph

sources:
  - src/cluster_periph_pkg.sv
  - src/periph_reg_if.sv
  - src/periph_bus_decode.sv
  - src/perf_counter_bank.sv
  - src/cluster_ctrl_regs.sv
  - src/periph_read_mux.sv
  - src/cluster_periph_top.sv
  - target: test
    files:
      - dv/tb_cluster_periph.sv
